/* common/core_config.svh */
// core configuration defines: reset pc, trap pc and register count
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// first fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

// fetch redirect on an illegal instruction, trap code sits here
`define CORE_TRAP_PC 32'h0000_0100

`define CORE_NREGS 32 // x0..x31, x0 reads as zero

`endif

/* common/rv32_isa_pkg.sv */
// rv32i subset isa package: opcodes, funct codes, format structs and instruction union
package rv32_isa_pkg;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011, // add, sub
    OPC_OP_IMM = 7'b0010011, // addi
    OPC_LOAD   = 7'b0000011, // lw
    OPC_STORE  = 7'b0100011, // sw
    OPC_BRANCH = 7'b1100011, // beq, bne
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011  // only ecall, used as halt
  } opcode_e;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_LW      = 3'b010;
  localparam logic [2:0] F3_SW      = 3'b010;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;
  localparam logic [6:0] F7_ADD     = 7'h00;
  localparam logic [6:0] F7_SUB     = 7'h20; // bit 5 picks subtract

  localparam logic [31:0] HALT_WORD = 32'h0000_0073; // ecall pattern

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } rtype_s;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } itype_s;

  typedef struct packed {
    logic [6:0] imm_hi; // imm[11:5]
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo; // imm[4:0]
    opcode_e    opcode;
  } stype_s;

  // branch offset bits are scattered, bit 0 is implied zero
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    opcode_e    opcode;
  } btype_s;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    opcode_e    opcode;
  } jtype_s;

  // one fetched word, read through whichever format the opcode implies
  typedef union packed {
    rtype_s      r;
    itype_s      i;
    stype_s      s;
    btype_s      b;
    jtype_s      j;
    logic [31:0] raw;
  } instr_u;

endpackage

/* common/pipe_ctrl_pkg.sv */
// pipeline control package: next-pc select and fetch/execute latch type
package pipe_ctrl_pkg;

  // where the pc goes when pc_en is high
  typedef enum logic {
    NPC_SEQ    = 1'b0, // pc + 4
    NPC_TARGET = 1'b1  // branch, jump or trap target from execute
  } npc_sel_e;

  // fetch/execute latch, 65 bits
  typedef struct packed {
    logic        valid; // entry holds a fetched instruction
    logic [31:0] pc;
    logic [31:0] instr; // raw word, execute views it as instr_u
  } fe_ex_s;

  localparam fe_ex_s FE_EX_EMPTY = '0; // bubble

endpackage

/* logic/hazard_unit.sv */
// hazard unit: stall, flush, pc enable and next-pc select for the two-stage core
`timescale 1ns/1ns

module hazard_unit (
  input  logic                    dren,
  input  logic                    dwen,
  input  logic                    jump,
  input  logic                    branch,
  input  logic                    mispredict,
  input  logic                    illegal,
  input  logic                    halt,
  input  logic                    iren,
  input  logic                    imem_busy,
  input  logic                    dmem_busy,
  output logic                    pc_en,
  output pipe_ctrl_pkg::npc_sel_e npc_sel,
  output logic                    fe_ex_stall,
  output logic                    fe_ex_flush
);
  import pipe_ctrl_pkg::*;

  logic dmem_access;
  logic wait_imem;   // fetch outstanding
  logic wait_dmem;   // load or store outstanding
  logic branch_jump; // taken branch or jal
  logic redirect;    // anything that sends fetch to target
  logic ex_flush;    // exception ready to flush

  assign dmem_access = dren | dwen;
  assign wait_imem   = iren & imem_busy;
  assign wait_dmem   = dmem_access & dmem_busy;
  assign branch_jump = jump | (branch & mispredict);
  assign redirect    = branch_jump | illegal;
  assign ex_flush    = illegal & ~wait_imem; // trap waits until iaddr may move

  assign npc_sel = redirect ? NPC_TARGET : NPC_SEQ;

  // pc only moves once the fetch is done, redirects included
  assign pc_en = ~wait_imem & ~wait_dmem & ~halt;

  // a redirect waiting on imem is held, anything else retiring under an imem
  // wait is flushed so it cannot execute twice
  assign fe_ex_flush = ex_flush | (branch_jump & ~wait_imem) |
                       (wait_imem & ~wait_dmem & ~redirect & ~halt);

  assign fe_ex_stall = (wait_dmem | (wait_imem & redirect) | halt) & ~ex_flush;

endmodule

/* core/fetch_stage.sv */
// fetch stage: program counter, instruction memory request and fetch/execute latch
`timescale 1ns/1ns

`include "core_config.svh"

module fetch_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  pc_en,
  input  pipe_ctrl_pkg::npc_sel_e npc_sel,
  input  logic [31:0]           target,
  input  logic                  fe_ex_stall,
  input  logic                  fe_ex_flush,
  input  logic [31:0]           irdata,
  input  logic                  imem_busy,
  output logic                  iren,
  output logic [31:0]           iaddr,
  output pipe_ctrl_pkg::fe_ex_s latch
);
  import pipe_ctrl_pkg::*;

  logic [31:0] pc_q;       // address being fetched
  logic [31:0] pc_next;
  logic        fetch_done; // irdata valid this cycle

  assign iren       = ~rst; // requests every cycle out of reset and the top level drops it on halt
  assign iaddr      = pc_q; // only moves with pc_en and so stays stable while busy
  assign fetch_done = iren & ~imem_busy;

  assign pc_next = (npc_sel == NPC_TARGET) ? target : pc_q + 32'd4;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= `CORE_RESET_PC;
    end else if (pc_en) begin
      pc_q <= pc_next; // sequential, redirect or trap
    end
  end

  // flush beats stall and a stalled latch keeps its entry
  always_ff @(posedge clk) begin
    if (rst) begin
      latch <= FE_EX_EMPTY;
    end else if (fe_ex_flush) begin
      latch.valid <= 1'b0; // wrong path or already retired
    end else if (!fe_ex_stall) begin
      latch.valid <= fetch_done; // bubble while the fetch still waits
      latch.pc    <= pc_q;
      latch.instr <= irdata;
    end
  end

endmodule

/* core/execute_stage.sv */
// execute stage: decoder, register file, alu, branch/jump resolution, data memory port, halt flag
`timescale 1ns/1ns

`include "core_config.svh"

module execute_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  pipe_ctrl_pkg::fe_ex_s latch,
  input  logic [31:0]           drdata,
  input  logic                  dmem_busy,
  output logic                  dren,
  output logic                  dwen,
  output logic [31:0]           daddr,
  output logic [31:0]           dwdata,
  output logic                  jump,
  output logic                  branch,
  output logic                  mispredict,
  output logic                  illegal,
  output logic                  halt,
  output logic [31:0]           target
);
  import rv32_isa_pkg::*;

  instr_u      ins;
  opcode_e     opc;
  logic        is_op, is_opimm, is_load, is_store, is_branch, is_jal, is_halt;
  logic        legal;
  logic        active; // valid entry and core not halted
  logic        exec;   // active and decodes cleanly
  logic [31:0] i_imm, s_imm, b_imm, j_imm;
  logic [31:0] rs1_val, rs2_val;
  logic [31:0] alu_res;
  logic        taken;
  logic        rf_wen;
  logic [31:0] rf_wdata;
  logic        halt_q;
  logic [31:0] regs [`CORE_NREGS];

  assign ins = latch.instr;
  assign opc = ins.r.opcode; // opcode sits in the same bits for every format

  always_comb begin
    is_op     = 1'b0;
    is_opimm  = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_halt   = 1'b0;
    case (opc)
      OPC_OP: begin
        is_op = 1'b1;
        legal = (ins.r.funct3 == F3_ADD_SUB) &&
                (ins.r.funct7 == F7_ADD || ins.r.funct7 == F7_SUB);
      end
      OPC_OP_IMM: begin
        is_opimm = 1'b1;
        legal    = (ins.i.funct3 == F3_ADD_SUB); // addi only
      end
      OPC_LOAD: begin
        is_load = 1'b1;
        legal   = (ins.i.funct3 == F3_LW); // word loads only
      end
      OPC_STORE: begin
        is_store = 1'b1;
        legal    = (ins.s.funct3 == F3_SW);
      end
      OPC_BRANCH: begin
        is_branch = 1'b1;
        legal     = (ins.b.funct3 == F3_BEQ) || (ins.b.funct3 == F3_BNE);
      end
      OPC_JAL: begin
        is_jal = 1'b1;
        legal  = 1'b1;
      end
      OPC_SYSTEM: begin
        is_halt = (ins.raw == HALT_WORD);
        legal   = is_halt; // any other system word traps
      end
      default: legal = 1'b0;
    endcase
  end

  assign active = latch.valid & ~halt_q;
  assign exec   = active & legal;

  // immediates rebuilt from the format views
  assign i_imm = {{20{ins.i.imm[11]}}, ins.i.imm};
  assign s_imm = {{20{ins.s.imm_hi[6]}}, ins.s.imm_hi, ins.s.imm_lo};
  assign b_imm = {{19{ins.b.imm12}}, ins.b.imm12, ins.b.imm11, ins.b.imm10_5,
                  ins.b.imm4_1, 1'b0};
  assign j_imm = {{11{ins.j.imm20}}, ins.j.imm20, ins.j.imm19_12, ins.j.imm11,
                  ins.j.imm10_1, 1'b0};

  assign rs1_val = (ins.r.rs1 == 5'd0) ? 32'd0 : regs[ins.r.rs1]; // x0 hardwired
  assign rs2_val = (ins.r.rs2 == 5'd0) ? 32'd0 : regs[ins.r.rs2];

  always_comb begin
    if (is_opimm) begin
      alu_res = rs1_val + i_imm;
    end else if (ins.r.funct7 == F7_SUB) begin
      alu_res = rs1_val - rs2_val;
    end else begin
      alu_res = rs1_val + rs2_val;
    end
  end

  assign dren   = exec & is_load;
  assign dwen   = exec & is_store;
  assign daddr  = rs1_val + (is_store ? s_imm : i_imm); // held by the stall while busy
  assign dwdata = rs2_val;

  assign taken      = (ins.b.funct3 == F3_BNE) ? (rs1_val != rs2_val) : (rs1_val == rs2_val);
  assign jump       = exec & is_jal;
  assign branch     = exec & is_branch;
  assign mispredict = exec & is_branch & taken; // not-taken prediction
  assign illegal    = active & ~legal;

  always_comb begin
    if (illegal) begin
      target = `CORE_TRAP_PC;
    end else if (is_jal) begin
      target = latch.pc + j_imm;
    end else begin
      target = latch.pc + b_imm;
    end
  end

  // retire, a load waits for its data
  assign rf_wen   = exec & (is_op | is_opimm | is_jal | (is_load & ~dmem_busy));
  assign rf_wdata = is_load ? drdata : (is_jal ? latch.pc + 32'd4 : alu_res);

  always_ff @(posedge clk) begin
    if (rf_wen && ins.r.rd != 5'd0) begin
      regs[ins.r.rd] <= rf_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      halt_q <= 1'b0;
    end else if (exec && is_halt) begin
      halt_q <= 1'b1; // sticky until reset
    end
  end

  assign halt = halt_q;

endmodule

/* core/core_top.sv */
// core top level: fetch stage, execute stage and hazard unit wired to both memory ports
`timescale 1ns/1ns

module core_top (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] irdata,
  input  logic        imem_busy,
  input  logic [31:0] drdata,
  input  logic        dmem_busy,
  output logic        iren,
  output logic        iaddr_unused_guard_n,
  output logic [31:0] iaddr,
  output logic        dren,
  output logic        dwen,
  output logic [31:0] daddr,
  output logic [31:0] dwdata,
  output logic        halted
);
  import pipe_ctrl_pkg::*;

  logic        pc_en;
  npc_sel_e    npc_sel;
  logic        fe_ex_stall;
  logic        fe_ex_flush;
  logic [31:0] target;
  fe_ex_s      latch;
  logic        fetch_iren; // raw request from fetch
  logic        jump, branch, mispredict, illegal, halt;

  assign iren   = fetch_iren & ~halt; // no fetches once halted
  assign halted = halt;

  assign iaddr_unused_guard_n = ~halt;

  fetch_stage i_fetch (
    .clk(clk), .rst(rst),
    .pc_en(pc_en), .npc_sel(npc_sel), .target(target),
    .fe_ex_stall(fe_ex_stall), .fe_ex_flush(fe_ex_flush),
    .irdata(irdata), .imem_busy(imem_busy),
    .iren(fetch_iren), .iaddr(iaddr), .latch(latch)
  );

  execute_stage i_execute (
    .clk(clk), .rst(rst), .latch(latch),
    .drdata(drdata), .dmem_busy(dmem_busy),
    .dren(dren), .dwen(dwen), .daddr(daddr), .dwdata(dwdata),
    .jump(jump), .branch(branch), .mispredict(mispredict),
    .illegal(illegal), .halt(halt), .target(target)
  );

  hazard_unit i_hazard (
    .dren(dren), .dwen(dwen), .jump(jump), .branch(branch),
    .mispredict(mispredict), .illegal(illegal), .halt(halt),
    .iren(iren), .imem_busy(imem_busy), .dmem_busy(dmem_busy),
    .pc_en(pc_en), .npc_sel(npc_sel),
    .fe_ex_stall(fe_ex_stall), .fe_ex_flush(fe_ex_flush)
  );

endmodule

/* tb/core_chk.sv */
// bound checks: fetch address hold, exclusive data enables, quiet memory ports after halt
`timescale 1ns/1ns

module core_chk (
  input logic        clk,
  input logic        rst,
  input logic        iren,
  input logic [31:0] iaddr,
  input logic        imem_busy,
  input logic        dren,
  input logic        dwen,
  input logic        halted
);

  // a waiting fetch keeps its address into the next cycle
  iaddr_hold: assert property (@(posedge clk) disable iff (rst)
    (iren && imem_busy) |=> $stable(iaddr))
    else $error("iaddr moved while the fetch was still busy");

  data_excl: assert property (@(posedge clk) disable iff (rst)
    !(dren && dwen))
    else $error("dren and dwen high in the same cycle"); // one data access at a time

  // halt is sticky, both ports stay idle from then on
  halt_quiet: assert property (@(posedge clk) disable iff (rst)
    halted |-> !(iren || dren || dwen))
    else $error("memory enable high after halted");

endmodule

/* tb/tb_top.sv */
// testbench for core_top: clock, reset, lfsr-timed memories, program image, reference iss, store compare
`timescale 1ns/1ns

`include "core_config.svh"

module tb_top;

  localparam int MAX_BUSY  = 4;   // address cycle plus up to 3 wait cycles
  localparam int ISS_STEPS = 500; // iss gives up after this many instructions

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic [31:0] irdata = '0;
  logic        imem_busy = 1'b1;
  logic [31:0] drdata = '0;
  logic        dmem_busy = 1'b1;
  logic        iren, dren, dwen, halted, guard_n;
  logic [31:0] iaddr, daddr, dwdata;

  logic [31:0] prog [256];                 // instruction image, word indexed
  logic [31:0] dmem [256];                 // data memory seen by the dut
  logic [31:0] lfsr = 32'h76a6_5fe7;
  logic [1:0]  icnt, dcnt;                 // wait cycles left in the current access
  logic [31:0] exp_addr [$];               // expected stores, in program order
  logic [31:0] exp_data [$];
  logic        exp_halted;
  int          mismatches = 0;
  int          other_errors = 0;
  int          timeouts = 0;
  int          n_exec;                     // instructions retired by the iss
  int          limit;                      // cycle budget for the run
  int          cycles = 0;

  initial begin
    forever #5 clk = ~clk; // 10 ns period
  end

  core_top i_dut (
    .clk(clk), .rst(rst),
    .irdata(irdata), .imem_busy(imem_busy), .drdata(drdata), .dmem_busy(dmem_busy),
    .iren(iren), .iaddr_unused_guard_n(guard_n), .iaddr(iaddr),
    .dren(dren), .dwen(dwen), .daddr(daddr), .dwdata(dwdata), .halted(halted)
  );

  bind core_top core_chk i_chk (
    .clk(clk), .rst(rst), .iren(iren), .iaddr(iaddr), .imem_busy(imem_busy),
    .dren(dren), .dwen(dwen), .halted(halted)
  );

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // two fresh lfsr bits give the wait length of one access
  function automatic logic [1:0] wait_cycles();
    logic [1:0] v;
    lfsr = lfsr_next(lfsr);
    v[0] = lfsr[0];
    lfsr = lfsr_next(lfsr);
    v[1] = lfsr[0];
    return v;
  endfunction

  // start-up data word where every byte lane depends on the whole word index
  function automatic logic [31:0] fill_word(input logic [7:0] idx);
    return {idx ^ 8'hc3, ~idx, idx + 8'h5a, idx};
  endfunction

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t ns: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic load_program();
    int k;
    for (k = 0; k < 256; k++) begin
      prog[k[7:0]] = 32'h0000_0000; // opcode 0 is illegal so strays land in the trap code
    end
    prog[0]  = 32'h0050_0093; // addi x1, x0, 5
    prog[1]  = 32'h0070_0113; // addi x2, x0, 7
    prog[2]  = 32'h0020_81b3; // add  x3, x1, x2
    prog[3]  = 32'h4011_0233; // sub  x4, x2, x1
    prog[4]  = 32'h0030_2023; // sw   x3, 0(x0)
    prog[5]  = 32'h0040_2223; // sw   x4, 4(x0)
    prog[6]  = 32'h0400_2283; // lw   x5, 64(x0)
    prog[7]  = 32'h0050_2423; // sw   x5, 8(x0), load-use
    prog[8]  = 32'h0010_8463; // beq  x1, x1, +8, taken
    prog[9]  = 32'h0010_2623; // sw   x1, 12(x0), skipped
    prog[10] = 32'h0010_9463; // bne  x1, x1, +8, falls through
    prog[11] = 32'h0020_2823; // sw   x2, 16(x0)
    prog[12] = 32'h0080_036f; // jal  x6, +8
    prog[13] = 32'h0010_2a23; // sw   x1, 20(x0), skipped
    prog[14] = 32'h0060_2c23; // sw   x6, 24(x0)
    prog[15] = 32'hffff_ffff; // illegal, traps
    prog[16] = 32'h0010_2e23; // sw   x1, 28(x0), wrong path
    prog[64] = 32'h0000_2383; // trap: lw x7, 0(x0)
    prog[65] = 32'h0053_8433; // add  x8, x7, x5
    prog[66] = 32'h0280_2023; // sw   x8, 32(x0)
    prog[67] = 32'h0000_0073; // halt
    prog[68] = 32'h0210_2223; // sw   x1, 36(x0), never reached
  endtask

  // architectural model of the subset that fills the expected store list
  function automatic int iss_run();
    logic [31:0] x [32];
    logic [31:0] mem [256];
    logic [31:0] pc, w, a, b, npc, wb, ea;
    logic        wr, ok;
    int          n;
    int          k;
    for (k = 0; k < 32; k++) begin
      x[k[4:0]] = '0;
    end
    for (k = 0; k < 256; k++) begin
      mem[k[7:0]] = fill_word(k[7:0]);
    end
    pc = `CORE_RESET_PC;
    n = 0;
    exp_halted = 1'b0;
    while (!exp_halted && n < ISS_STEPS) begin
      w   = prog[pc[9:2]];
      a   = x[w[19:15]];
      b   = x[w[24:20]];
      npc = pc + 32'd4;
      wr  = 1'b0;
      wb  = '0;
      ok  = 1'b1;
      n++;
      case (w[6:0])
        7'b0110011: begin // add, sub
          ok = w[14:12] == 3'b000 && (w[31:25] == 7'h00 || w[31:25] == 7'h20);
          wr = 1'b1;
          wb = w[30] ? a - b : a + b;
        end
        7'b0010011: begin // addi
          ok = w[14:12] == 3'b000;
          wr = 1'b1;
          wb = a + {{20{w[31]}}, w[31:20]};
        end
        7'b0000011: begin // lw
          ok = w[14:12] == 3'b010;
          ea = a + {{20{w[31]}}, w[31:20]};
          wr = 1'b1;
          wb = mem[ea[9:2]];
        end
        7'b0100011: begin // sw
          ok = w[14:12] == 3'b010;
          ea = a + {{20{w[31]}}, w[31:25], w[11:7]};
          if (ok) begin
            exp_addr.push_back(ea);
            exp_data.push_back(b);
            mem[ea[9:2]] = b;
          end
        end
        7'b1100011: begin // beq, bne
          ok = w[14:13] == 2'b00;
          if ((a == b) != w[12]) begin
            npc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
          end
        end
        7'b1101111: begin // jal
          wr  = 1'b1;
          wb  = pc + 32'd4;
          npc = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        end
        7'b1110011: begin // halt is the ecall word
          ok = w == 32'h0000_0073;
          exp_halted = ok;
        end
        default: ok = 1'b0;
      endcase
      if (!ok) begin
        npc = `CORE_TRAP_PC; // no side effects and fetch restarts at the trap code
      end else if (wr && w[11:7] != 5'd0) begin
        x[w[11:7]] = wb;
      end
      pc = npc;
    end
    return n;
  endfunction

  // both memories hold busy high in the address cycle then 0 to 3 more wait cycles
  always @(posedge clk) begin : mem_models
    int k;
    if (rst || !imem_busy) begin
      imem_busy <= 1'b1;            // next fetch, address settles this cycle
      icnt      <= wait_cycles();
    end else if (icnt == 2'd0) begin
      imem_busy <= 1'b0;
      irdata    <= prog[iaddr[9:2]];
    end else begin
      icnt <= icnt - 2'd1;
    end
    if (rst) begin
      dmem_busy <= 1'b1;
      dcnt      <= wait_cycles();
      for (k = 0; k < 256; k++) begin
        dmem[k[7:0]] <= fill_word(k[7:0]);
      end
    end else if (!(dren || dwen) || !dmem_busy) begin
      if (dwen && !dmem_busy) begin
        dmem[daddr[9:2]] <= dwdata; // store completed in the cycle just ended
      end
      dmem_busy <= 1'b1;
      dcnt      <= wait_cycles();
    end else if (dcnt == 2'd0) begin
      dmem_busy <= 1'b0;
      drdata    <= dmem[daddr[9:2]];
    end else begin
      dcnt <= dcnt - 2'd1;
    end
  end

  // each completed store is checked against the iss list in order
  always @(posedge clk) begin
    if (!rst && dwen && !dmem_busy) begin
      if (exp_addr.size() == 0) begin
        other_errors++;
        $display("Unexpected store at %0t ns to address %h", $time, daddr);
      end else begin
        check_word("daddr", daddr, exp_addr.pop_front());
        check_word("dwdata", dwdata, exp_data.pop_front());
      end
    end
  end

  initial begin
    load_program();
    n_exec = iss_run();
    limit  = 40 * n_exec * MAX_BUSY;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    while (!halted && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (!halted) begin
      timeouts++;
      $display("Timeout: core did not halt within %0d cycles", limit);
    end
    repeat (20) @(posedge clk); // a store after halt would show up here
    check_bit("halted", halted, exp_halted);
    check_bit("iren", iren, !exp_halted);
    check_bit("iaddr_unused_guard_n", guard_n, !exp_halted);
    if (exp_addr.size() != 0) begin
      other_errors++;
      $display("Missing stores: %0d expected stores never completed", exp_addr.size());
    end
    $display("mismatches=%0d other_errors=%0d timeouts=%0d",
             mismatches, other_errors, timeouts);
    if (mismatches + other_errors + timeouts == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+common
common/rv32_isa_pkg.sv
common/pipe_ctrl_pkg.sv
logic/hazard_unit.sv
core/fetch_stage.sv
core/execute_stage.sv
core/core_top.sv
tb/core_chk.sv
tb/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# build the core testbench with verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f -o tb_sim
./obj_dir/tb_sim | tee sim.log

if grep -q "Regression failed" sim.log || ! grep -q "Regression passed" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"
